//--- Makefile
VERILATOR ?= verilator
TOP ?= tbPsramCtrl
LINT_TOP ?= psramCtrlTop
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT ?= Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the simulation output.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- design/busSequencer.sv
`timescale 1ns/1ps

module busSequencer
	import psramPkg::*;
(
	input logic iClk,
	input logic iRst_N,
	input logic cfgStart,	// From the init sequencer.
	input queueEntry_t headEntry,
	input logic empty,
	output logic pop,
	output logic ready,	// Mode registers written.
	output logic psramCe_N,
	output byte_t dqOutRise,	// Byte for the rising edge.
	output byte_t dqOutFall,	// Byte for the falling edge.
	output logic dqOe,
	input byte_t dqInRise,
	input byte_t dqInFall,
	output logic rdValid,
	output word_t rdData
);

	busState_t state;
	logic [7:0] frameCnt;	// Frame cycle now on the lanes.
	logic [MODE_REG_IDX_W-1:0] cfgIdx;	// Mode register being written.
	logic cfgActive;	// Mode register frames in progress.
	queueEntry_t curEntry;	// Operation of the running frame.
	opKind_t headKind;
	opKind_t curKind;
	psramAddr_t curAddr;
	word_t curData;
	logic [7:0] lastCycle;	// Data cycle and last frame cycle.
	logic capValid;	// Read word captured last cycle.
	word_t capData;

	// Entry fields as laid out in the package.
	assign headKind = opKind_t'(headEntry[48]);
	assign curKind = opKind_t'(curEntry[48]);
	assign curAddr = curEntry[47:16];
	assign curData = curEntry[15:0];
	assign lastCycle = (curKind == OP_READ) ? RD_LATENCY : WR_LATENCY;

	// Take the head as the frame launches from idle.
	assign pop = (state == idle) && ready && !empty;

	always_ff @(posedge iClk)
	begin
		if (pop)
			curEntry <= headEntry;
		if (state == data && !cfgActive && curKind == OP_READ)
			capData <= {dqInRise, dqInFall};	// Sample point with the high byte on rise.
		if (capValid)
			rdData <= capData;
	end

	always_ff @(posedge iClk or negedge iRst_N)
	begin
		if (!iRst_N)
		begin
			state <= idle;
			frameCnt <= '0;
			cfgIdx <= '0;
			cfgActive <= 1'b0;
			ready <= 1'b0;
			psramCe_N <= 1'b1;
			dqOutRise <= '0;
			dqOutFall <= '0;
			dqOe <= 1'b0;
			capValid <= 1'b0;
			rdValid <= 1'b0;
		end
		else
		begin
			capValid <= 1'b0;
			rdValid <= capValid;	// Two cycles after the sample cycle.
			case (state)
				idle:
					if (!ready && !cfgActive && cfgStart)
					begin
						cfgActive <= 1'b1;
						cfgIdx <= '0;
						state <= configure;
					end
					else if (pop)
					begin
						psramCe_N <= 1'b0;	// Frame cycle 0 starts.
						dqOe <= 1'b1;
						dqOutRise <= (headKind == OP_READ) ? CMD_SYNC_RD : CMD_SYNC_WR;
						dqOutFall <= (headKind == OP_READ) ? CMD_SYNC_RD : CMD_SYNC_WR;
						frameCnt <= '0;
						state <= cmd;
					end
				configure:
				begin
					psramCe_N <= 1'b0;
					dqOe <= 1'b1;
					dqOutRise <= CMD_MODE_REG_WR;
					dqOutFall <= CMD_MODE_REG_WR;
					frameCnt <= '0;
					state <= cmd;
				end
				cmd:
				begin
					// Cycle 1 carries address bytes 3 and 2.
					dqOutRise <= cfgActive ? 8'h00 : curAddr[31:24];
					dqOutFall <= cfgActive ? 8'h00 : curAddr[23:16];
					frameCnt <= frameCnt + 8'd1;
					state <= addr;
				end
				addr:
				begin
					frameCnt <= frameCnt + 8'd1;
					if (frameCnt == 8'd1)
					begin
						// Cycle 2 carries address bytes 1 and 0 or the MR address.
						dqOutRise <= cfgActive ? 8'h00 : curAddr[15:8];
						dqOutFall <= cfgActive ? MODE_REG_ADDR[cfgIdx] : curAddr[7:0];
					end
					else if (cfgActive)
					begin
						dqOutRise <= MODE_REG_DATA[cfgIdx];	// MR data at cycle 3.
						dqOutFall <= 8'h00;
						state <= data;
					end
					else
					begin
						dqOutRise <= 8'h00;
						dqOutFall <= 8'h00;
						dqOe <= (curKind == OP_WRITE);	// Reads release the bus here.
						state <= latency;
					end
				end
				latency:
				begin
					frameCnt <= frameCnt + 8'd1;
					if (frameCnt + 8'd1 == lastCycle)
					begin
						if (curKind == OP_WRITE)
						begin
							dqOutRise <= curData[15:8];
							dqOutFall <= curData[7:0];
						end
						state <= data;
					end
				end
				data:
				begin
					psramCe_N <= 1'b1;	// End of frame.
					dqOe <= 1'b0;
					dqOutRise <= 8'h00;
					dqOutFall <= 8'h00;
					capValid <= !cfgActive && (curKind == OP_READ);
					state <= finish;
				end
				finish:
					if (cfgActive && cfgIdx == MODE_REG_IDX_W'(MODE_REG_COUNT - 1))
					begin
						cfgActive <= 1'b0;
						ready <= 1'b1;	// Table written so the host may start.
						state <= idle;
					end
					else if (cfgActive)
					begin
						cfgIdx <= cfgIdx + MODE_REG_IDX_W'(1);
						state <= configure;
					end
					else
						state <= idle;
				default:
					state <= idle;
			endcase
		end
	end

	// Config start only lands on an idle bus that is not yet configured.
	assertCfgStartIdle: assert property (@(posedge iClk) disable iff (!iRst_N)
		cfgStart |-> state == idle && !ready && !cfgActive);

endmodule

//--- design/hostPort.sv
`timescale 1ns/1ps

module hostPort
	import psramPkg::*;
(
	input logic iClk,
	input logic iRst_N,
	input logic opReq,	// Four-phase request from the host.
	input opKind_t opKind,
	input psramAddr_t opAddr,
	input word_t opWrData,
	input logic ready,	// Device configured.
	input logic full,	// Queue has no free slot.
	output logic opAck,
	output logic push,
	output queueEntry_t pushEntry
);

	logic pushed;	// Request pushed last cycle.

	// Host holds the fields steady while opReq is high.
	assign pushEntry = {opKind, opAddr, opWrData};

	// One push per request. Ack low is the idle phase.
	assign push = opReq && !opAck && !pushed && ready && !full;

	always_ff @(posedge iClk or negedge iRst_N)
	begin
		if (!iRst_N)
		begin
			pushed <= 1'b0;
			opAck <= 1'b0;
		end
		else
		begin
			pushed <= push;
			if (pushed)
				opAck <= 1'b1;	// Ack one cycle after the push.
			else if (!opReq)
				opAck <= 1'b0;	// Host released the request.
		end
	end

	// The host keeps a pending request and its fields steady until the ack.
	assertReqHeld: assert property (@(posedge iClk) disable iff (!iRst_N)
		opReq && !opAck |=> opAck || (opReq && $stable(pushEntry)));

endmodule

//--- design/initSequencer.sv
`timescale 1ns/1ps

module initSequencer
	import psramPkg::*;
(
	input logic iClk,
	input logic iRst_N,
	output logic psramRst_N,	// Device reset, active low.
	output logic cfgStart	// One pulse, starts mode register writes.
);

	initState_t state;
	logic [15:0] cnt;	// Cycle counter for the current state.

	always_ff @(posedge iClk or negedge iRst_N)
	begin
		if (!iRst_N)
		begin
			state <= waitPower;
			cnt <= '0;
			psramRst_N <= 1'b1;	// Device reset idles high.
			cfgStart <= 1'b0;
		end
		else
		begin
			cfgStart <= 1'b0;	// Default, pulse only.
			case (state)
				waitPower:
					// Let the device supply settle.
					if (cnt == POWER_UP_CYCLES - 16'd1)
					begin
						cnt <= '0;
						psramRst_N <= 1'b0;	// Start the reset pulse.
						state <= rstLow;
					end
					else
						cnt <= cnt + 16'd1;
				rstLow:
					if (cnt == {8'd0, RST_LOW_CYCLES} - 16'd1)
					begin
						cnt <= '0;
						psramRst_N <= 1'b1;	// Release reset.
						state <= rstHigh;
					end
					else
						cnt <= cnt + 16'd1;
				rstHigh:
				begin
					cfgStart <= 1'b1;	// Recovery cycle done, hand over to the bus.
					state <= done;
				end
				done:
					state <= done;	// Stay here until the next reset.
				default:
					state <= waitPower;
			endcase
		end
	end

endmodule

//--- design/opQueue.sv
`timescale 1ns/1ps

module opQueue
	import psramPkg::*;
(
	input logic iClk,
	input logic iRst_N,
	input logic push,
	input queueEntry_t pushEntry,
	input logic pop,
	output queueEntry_t headEntry,
	output logic empty,
	output logic full
);

	queueEntry_t mem [QUEUE_DEPTH];	// Pending operations.
	logic [QUEUE_PTR_W-1:0] wrPtr;	// Next free slot.
	logic [QUEUE_PTR_W-1:0] rdPtr;	// Oldest entry.
	logic [QUEUE_CNT_W-1:0] count;	// Entries held.

	assign headEntry = mem[rdPtr];	// Oldest entry when not empty.
	assign empty = (count == '0);
	assign full = (count == QUEUE_CNT_W'(QUEUE_DEPTH));

	// Entry storage.
	always_ff @(posedge iClk)
	begin
		if (push)
			mem[wrPtr] <= pushEntry;
	end

	// Pointers wrap by overflow on a power-of-two depth.
	always_ff @(posedge iClk or negedge iRst_N)
	begin
		if (!iRst_N)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= wrPtr + QUEUE_PTR_W'(1);
			if (pop)
				rdPtr <= rdPtr + QUEUE_PTR_W'(1);
			case ({push, pop})
				2'b10: count <= count + QUEUE_CNT_W'(1);	// Fill.
				2'b01: count <= count - QUEUE_CNT_W'(1);	// Drain.
				default: count <= count;	// Both or neither.
			endcase
		end
	end

	// The bus side only takes an entry that exists.
	assertPopNotEmpty: assert property (@(posedge iClk) disable iff (!iRst_N)
		pop |-> !empty);

endmodule

//--- design/psramCtrlTop.sv
`timescale 1ns/1ps

module psramCtrlTop
	import psramPkg::*;
(
	input logic iClk,
	input logic iRst_N,
	input logic opReq,
	input opKind_t opKind,
	input psramAddr_t opAddr,
	input word_t opWrData,
	output logic opAck,
	output logic ready,
	output logic rdValid,
	output word_t rdData,
	output logic psramCe_N,
	output logic psramRst_N,
	output byte_t dqOutRise,
	output byte_t dqOutFall,
	output logic dqOe,
	input byte_t dqInRise,
	input byte_t dqInFall
);

	logic push;
	logic pop;
	logic empty;
	logic full;
	logic cfgStart;
	queueEntry_t pushEntry;
	queueEntry_t headEntry;

	hostPort uHostPort (
		.iClk(iClk), .iRst_N(iRst_N),
		.opReq(opReq), .opKind(opKind), .opAddr(opAddr), .opWrData(opWrData),
		.ready(ready), .full(full),
		.opAck(opAck), .push(push), .pushEntry(pushEntry)
	);

	opQueue uOpQueue (
		.iClk(iClk), .iRst_N(iRst_N),
		.push(push), .pushEntry(pushEntry), .pop(pop),
		.headEntry(headEntry), .empty(empty), .full(full)
	);

	initSequencer uInitSequencer (
		.iClk(iClk), .iRst_N(iRst_N),
		.psramRst_N(psramRst_N), .cfgStart(cfgStart)
	);

	busSequencer uBusSequencer (
		.iClk(iClk), .iRst_N(iRst_N),
		.cfgStart(cfgStart), .headEntry(headEntry), .empty(empty), .pop(pop),
		.ready(ready), .psramCe_N(psramCe_N),
		.dqOutRise(dqOutRise), .dqOutFall(dqOutFall), .dqOe(dqOe),
		.dqInRise(dqInRise), .dqInFall(dqInFall),
		.rdValid(rdValid), .rdData(rdData)
	);

endmodule

//--- design/psramPkg.sv
package psramPkg;

	// Bus and host widths.
	typedef logic [31:0] psramAddr_t;	// Device byte address.
	typedef logic [15:0] word_t;	// One host data word.
	typedef logic [7:0] byte_t;	// One DDR lane byte.

	// Host operation kind.
	typedef enum logic
	{
		OP_WRITE = 1'b0,
		OP_READ  = 1'b1
	} opKind_t;

	// Queue entry layout is {kind, address, data}.
	localparam int ENTRY_W = 1 + 32 + 16;
	typedef logic [ENTRY_W-1:0] queueEntry_t;

	// Command bytes, sent on both lanes in frame cycle 0.
	localparam byte_t CMD_SYNC_WR = 8'h80;
	localparam byte_t CMD_SYNC_RD = 8'h00;
	localparam byte_t CMD_MODE_REG_WR = 8'hC0;

	// Power-up timing, in iClk cycles.
	localparam logic [15:0] POWER_UP_CYCLES = 16'd100;	// Wait before the reset pulse.
	localparam logic [7:0] RST_LOW_CYCLES = 8'd2;	// Device reset low time.

	// Frame cycles for data.
	localparam logic [7:0] WR_LATENCY = 8'd7;	// Write data driven here.
	localparam logic [7:0] RD_LATENCY = 8'd9;	// Read data sampled here.

	// Mode register table, written in order after reset.
	localparam int MODE_REG_COUNT = 4;
	localparam int MODE_REG_IDX_W = $clog2(MODE_REG_COUNT);
	localparam byte_t MODE_REG_ADDR [MODE_REG_COUNT] = '{8'h00, 8'h04, 8'h08, 8'h01};
	localparam byte_t MODE_REG_DATA [MODE_REG_COUNT] = '{8'h11, 8'h20, 8'h03, 8'h40};

	// Operation queue sizing.
	localparam int QUEUE_DEPTH = 2;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = QUEUE_PTR_W + 1;	// Count must reach QUEUE_DEPTH.

	// Power-up sequencer states.
	typedef enum logic [1:0]
	{
		waitPower,	// Counting the power-up wait.
		rstLow,	// Device reset held low.
		rstHigh,	// One cycle of recovery.
		done	// Parked until reset.
	} initState_t;

	// Bus frame sequencer states.
	typedef enum logic [2:0]
	{
		idle,
		cmd,	// Command cycle on the lanes.
		addr,	// Address or mode register address cycles.
		latency,	// Waiting for the data cycle.
		data,	// Last frame cycle.
		finish,	// CE# high gap.
		configure	// Launch of the next mode register frame.
	} busState_t;

endpackage

//--- filelist.f
design/psramPkg.sv
design/hostPort.sv
design/opQueue.sv
design/initSequencer.sv
design/busSequencer.sv
design/psramCtrlTop.sv
testbench/psramModel.sv
testbench/tbPsramCtrl.sv

//--- testbench/psramModel.sv
`timescale 1ns/1ps

module psramModel
	import psramPkg::*;
(
	input logic iClk,
	input logic psramRst_N,
	input logic psramCe_N,
	input byte_t dqOutRise,
	input byte_t dqOutFall,
	input logic dqOe,
	output byte_t dqInRise,	// Read data, high byte.
	output byte_t dqInFall	// Read data, low byte.
);

	word_t mem [psramAddr_t];	// Written words by byte address.
	byte_t mrValue [256];	// Mode registers by address.
	int mrCount;	// Mode register frames seen.
	int rstPulses;	// Falling edges of the device reset.
	int frameCount;	// Frames started.
	int busErrors;	// Frame cycles that broke the lane rules.
	int cycle;	// Frame cycle on the lanes at this edge.
	byte_t command;	// Command of the running frame.
	psramAddr_t frameAddr;
	byte_t mrAddr;
	word_t rdWord;

	initial
	begin
		int i;
		mrCount = 0;
		rstPulses = 0;
		frameCount = 0;
		busErrors = 0;
		cycle = 0;
		command = 8'h00;
		frameAddr = '0;
		mrAddr = 8'h00;
		rdWord = '0;
		dqInRise = 8'h00;
		dqInFall = 8'h00;
		for (i = 0; i < 256; i++)
			mrValue[i] = 8'h00;
	end

	always @(negedge psramRst_N)
		rstPulses <= rstPulses + 1;

	// The device ignores the lanes while its reset is low.
	always @(posedge iClk)
	begin
		logic expectOe;
		if (psramCe_N !== 1'b0 || psramRst_N !== 1'b1)
			cycle <= 0;	// Deselected, next frame starts at cycle 0.
		else
		begin
			cycle <= cycle + 1;
			if (cycle == 0)
			begin
				command <= dqOutRise;
				frameCount++;
				if (dqOutRise !== dqOutFall)
					busErrors++;	// Command goes on both lanes.
			end
			expectOe = (cycle < 3) || (command != CMD_SYNC_RD);	// Reads turn the bus at 3.
			if (dqOe !== expectOe)
				busErrors++;
			if (command == CMD_MODE_REG_WR)
			begin
				if (cycle == 2)
					mrAddr <= dqOutFall;
				if (cycle == 3)
				begin
					mrValue[mrAddr] = dqOutRise;	// MR data on the rise lane.
					mrCount++;
				end
			end
			else
			begin
				if (cycle == 1)
					frameAddr[31:16] <= {dqOutRise, dqOutFall};	// Bytes 3 and 2.
				if (cycle == 2)
					frameAddr[15:0] <= {dqOutRise, dqOutFall};	// Bytes 1 and 0.
				if (command == CMD_SYNC_WR && cycle == int'(WR_LATENCY))
					mem[frameAddr] = {dqOutRise, dqOutFall};
				if (command == CMD_SYNC_RD && cycle == int'(RD_LATENCY) - 1)
				begin
					// Unwritten words read back as the inverted low address.
					rdWord = mem.exists(frameAddr) ? mem[frameAddr] : ~frameAddr[15:0];
					dqInRise <= rdWord[15:8];	// Held through the sample cycle.
					dqInFall <= rdWord[7:0];
				end
				if (cycle == int'(RD_LATENCY))
				begin
					dqInRise <= 8'h00;
					dqInFall <= 8'h00;
				end
			end
		end
	end

endmodule

//--- testbench/tbPsramCtrl.sv
`timescale 1ns/1ps

module tbPsramCtrl
	import psramPkg::*;
();

	// Power-up plus a generous bound per host operation.
	localparam int INIT_CYCLES = int'(POWER_UP_CYCLES) + int'(RST_LOW_CYCLES) + 2
		+ MODE_REG_COUNT * 8;
	localparam int OP_CYCLES = int'(RD_LATENCY) + 8;	// Frame, CE# gap and handshake.
	localparam int OP_COUNT = 2 + 16 + 4 + 1;	// Host operations over all tests.
	localparam int WATCHDOG_CYCLES = 2 * (8 + INIT_CYCLES + OP_COUNT * OP_CYCLES);

	logic iClk;
	logic iRst_N;
	logic opReq;
	opKind_t opKind;
	psramAddr_t opAddr;
	word_t opWrData;
	logic opAck;
	logic ready;
	logic rdValid;
	word_t rdData;
	logic psramCe_N;
	logic psramRst_N;
	byte_t dqOutRise;
	byte_t dqOutFall;
	logic dqOe;
	byte_t dqInRise;
	byte_t dqInFall;

	logic [31:0] lcgState;
	word_t expMem [psramAddr_t];	// Last word written per address.
	word_t expQ [$];	// Expected read words in issue order.
	word_t rdQ [$];	// Words seen with rdValid.
	psramAddr_t randAddr [8];
	string testName;
	int testErrors;
	int totalErrors;
	int testsRun;
	int testsFailed;
	int reqFrames;	// Frames started when the request went up.
	int ackFrames;	// Frames started when the ack was seen.

	psramCtrlTop uut (
		.iClk(iClk), .iRst_N(iRst_N),
		.opReq(opReq), .opKind(opKind), .opAddr(opAddr), .opWrData(opWrData),
		.opAck(opAck), .ready(ready), .rdValid(rdValid), .rdData(rdData),
		.psramCe_N(psramCe_N), .psramRst_N(psramRst_N),
		.dqOutRise(dqOutRise), .dqOutFall(dqOutFall), .dqOe(dqOe),
		.dqInRise(dqInRise), .dqInFall(dqInFall)
	);

	psramModel model (
		.iClk(iClk), .psramRst_N(psramRst_N), .psramCe_N(psramCe_N),
		.dqOutRise(dqOutRise), .dqOutFall(dqOutFall), .dqOe(dqOe),
		.dqInRise(dqInRise), .dqInFall(dqInFall)
	);

	initial
	begin
		iClk = 1'b0;
		forever #5 iClk = ~iClk;	// 10 ns period.
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge iClk);
		$display("Timeout after %0d cycles, a handshake or read never completed",
			WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	always @(negedge iClk)
		if (rdValid === 1'b1)
			rdQ.push_back(rdData);	// Collect read words as they come.

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic word_t expectedWord(input psramAddr_t addr);
		if (expMem.exists(addr))
			return expMem[addr];
		return ~addr[15:0];	// Never written.
	endfunction

	task automatic expectEqual(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %s: %s expected %h actual %h", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		testsRun++;
		totalErrors += testErrors;
		if (testErrors == 0)
			$display("test %s: ok", testName);
		else
		begin
			$display("test %s: %0d mismatches", testName, testErrors);
			testsFailed++;
		end
	endtask

	// Four-phase handshake started on a falling edge.
	task automatic issueOp(input opKind_t kind, input psramAddr_t addr, input word_t wrData);
		opReq = 1'b1;
		opKind = kind;
		opAddr = addr;
		opWrData = wrData;
		reqFrames = model.frameCount;
		@(negedge iClk);
		while (!opAck)
			@(negedge iClk);
		ackFrames = model.frameCount;
		opReq = 1'b0;
		@(negedge iClk);
		while (opAck)
			@(negedge iClk);
		if (kind == OP_WRITE)
			expMem[addr] = wrData;
		else
			expQ.push_back(expectedWord(addr));	// Operations run in issue order.
	endtask

	task automatic checkReads();
		word_t want;
		word_t got;
		while (rdQ.size() < expQ.size())
			@(negedge iClk);
		while (expQ.size() > 0)
		begin
			want = expQ.pop_front();
			got = rdQ.pop_front();
			expectEqual("read data", {16'd0, want}, {16'd0, got});
		end
	endtask

	task automatic initSequence();
		int i;
		startTest("init");
		expectEqual("outputs after reset", 32'b11,
			{26'd0, ready, opAck, rdValid, dqOe, psramCe_N, psramRst_N});
		while (!ready)
			@(negedge iClk);
		expectEqual("reset pulses", 32'd1, 32'(model.rstPulses));
		expectEqual("mode register writes", 32'(MODE_REG_COUNT), 32'(model.mrCount));
		for (i = 0; i < MODE_REG_COUNT; i++)
			expectEqual("mode register value", {24'd0, MODE_REG_DATA[i]},
				{24'd0, model.mrValue[MODE_REG_ADDR[i]]});
		endTest();
	endtask

	task automatic writeThenRead();
		startTest("write then read");
		issueOp(OP_WRITE, 32'h0000_1000, 16'hbeef);
		issueOp(OP_READ, 32'h0000_1000, 16'h0000);
		checkReads();
		endTest();
	endtask

	task automatic randomWords();
		logic [31:0] r;
		int i;
		startTest("random words");
		for (i = 0; i < 8; i++)
		begin
			randAddr[i] = nextRand() & 32'h7fff_fffe;	// Even with the top bit clear.
			r = nextRand();
			issueOp(OP_WRITE, randAddr[i], r[23:8]);
		end
		for (i = 0; i < 8; i++)
			issueOp(OP_READ, randAddr[i], 16'h0000);
		checkReads();
		endTest();
	endtask

	task automatic backPressure();
		startTest("back pressure");
		issueOp(OP_READ, randAddr[7], 16'h0000);	// Bus takes it at once.
		issueOp(OP_READ, randAddr[0], 16'h0000);
		issueOp(OP_READ, randAddr[3], 16'h0000);	// Queue is full now.
		issueOp(OP_READ, 32'h0000_2000, 16'h0000);
		expectEqual("ack only after a pop", 32'd1, 32'(ackFrames > reqFrames));
		checkReads();
		endTest();
	endtask

	task automatic unwrittenRead();
		startTest("unwritten read");
		issueOp(OP_READ, 32'h8765_4320, 16'h0000);	// Expect 16'hbcdf.
		checkReads();
		expectEqual("frame address", 32'h8765_4320, model.frameAddr);
		expectEqual("bus rule violations", 32'd0, 32'(model.busErrors));
		expectEqual("extra read words", 32'd0, 32'(rdQ.size()));
		endTest();
	endtask

	initial
	begin
		iRst_N = 1'b0;
		opReq = 1'b0;
		opKind = OP_WRITE;
		opAddr = '0;
		opWrData = '0;
		lcgState = 32'h672d;
		totalErrors = 0;
		testsRun = 0;
		testsFailed = 0;
		repeat (8) @(negedge iClk);
		iRst_N = 1'b1;	// Release away from the rising edge.
		initSequence();
		writeThenRead();
		randomWords();
		backPressure();
		unwrittenRead();
		$display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
			testsRun, testsFailed, totalErrors);
		if (totalErrors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
